//--- design/n64_cfg_pkg.sv
package n64_cfg_pkg;

    // ------------------------------------------------------------
    // Register map and opcodes
    // ------------------------------------------------------------

    // Register index, taken from address bits 4 down to 1.
    typedef enum logic [3:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA_0_H,
        REG_DATA_0_L,
        REG_DATA_1_H,
        REG_DATA_1_L,
        REG_IDENTIFIER_H,
        REG_IDENTIFIER_L,
        REG_KEY_H,
        REG_KEY_L,
        REG_IRQ_H,
        REG_IRQ_L
    } e_reg;

    typedef enum logic [7:0] {
        CMD_ECHO      = 8'd1,
        CMD_SWAP      = 8'd2,
        CMD_ADD       = 8'd3,
        CMD_RAISE_IRQ = 8'd4
    } e_cmd;

    // Key words the host writes, in order, to open the register window.
    localparam int UNLOCK_KEY_LEN = 4;
    localparam logic [15:0] UNLOCK_KEY [UNLOCK_KEY_LEN] = '{
        16'h5F55,
        16'h4E4C,
        16'h4F43,
        16'h4B5F
    };

    localparam logic [15:0] LOCK_WORD = 16'hFFFF;

    // ------------------------------------------------------------
    // Stage to stage payloads
    // ------------------------------------------------------------

    typedef struct packed {
        logic        hit;
        logic        write;
        e_reg        index;
        logic [15:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic             pending;
        e_cmd             cmd;
        logic [1:0][31:0] arg;
    } cfg_cmd_t;

    typedef struct packed {
        logic             done;
        logic             error;
        logic             ctrl_irq;
        logic [1:0][31:0] result;
    } cfg_rsp_t;

endpackage

//--- design/n64_bus_decode.sv
`timescale 1ns/1ps

module n64_bus_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [16:0]           address,
    input  logic                  write,
    input  logic [15:0]           wdata,
    output n64_cfg_pkg::reg_req_t req
);

    import n64_cfg_pkg::*;

    logic window_hit;

    // The configuration window sits at the start of the upper 64 kB half.
    assign window_hit = address[16] && (address[15:5] == 11'd0);

    always_ff @(posedge clk) begin
        req.hit   <= window_hit;
        req.index <= e_reg'(address[4:1]);
        req.wdata <= wdata;

        if (reset) begin
            req.write <= 1'b0;
        end else begin
            req.write <= write;
        end
    end

endmodule

//--- design/n64_cfg.sv
`timescale 1ns/1ps

module n64_cfg #(
    parameter logic [31:0] IDENTIFIER = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  n64_reset,
    input  logic                  n64_nmi,
    input  n64_cfg_pkg::reg_req_t req,
    output n64_cfg_pkg::cfg_cmd_t cmd_out,
    input  n64_cfg_pkg::cfg_rsp_t rsp,
    output logic [15:0]           rdata,
    output logic                  irq
);

    import n64_cfg_pkg::*;

    localparam logic [1:0] KEY_LAST = 2'(UNLOCK_KEY_LEN - 1);

    logic       unlock;
    logic       unlock_flag;
    logic [1:0] unlock_count;
    logic       lock_count;
    logic       cmd_error;
    logic       cmd_irq_request;
    logic       cmd_irq;
    logic       ctrl_irq;
    logic       write_hit;
    logic       key_write;
    logic       console_reset;

    assign write_hit = req.hit && req.write;
    assign key_write = write_hit && ((req.index == REG_KEY_H) || (req.index == REG_KEY_L));
    assign console_reset = n64_reset || n64_nmi;

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------

    always_comb begin
        rdata = 16'd0;
        if (req.hit) begin
            case (req.index)
                REG_STATUS:       rdata = {cmd_out.pending, cmd_error, ctrl_irq, cmd_irq, 12'd0};
                REG_COMMAND:      rdata = {7'd0, cmd_irq_request, cmd_out.cmd};
                REG_DATA_0_H:     rdata = rsp.result[0][31:16];
                REG_DATA_0_L:     rdata = rsp.result[0][15:0];
                REG_DATA_1_H:     rdata = rsp.result[1][31:16];
                REG_DATA_1_L:     rdata = rsp.result[1][15:0];
                REG_IDENTIFIER_H: rdata = IDENTIFIER[31:16];
                REG_IDENTIFIER_L: rdata = IDENTIFIER[15:0];
                default:          rdata = 16'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= cmd_irq || ctrl_irq;
        end
    end

    // ------------------------------------------------------------
    // Unlock key sequencer
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            unlock_flag  <= 1'b0;
            unlock_count <= 2'd0;
        end else begin
            unlock_flag <= 1'b0;
            if (console_reset) begin
                unlock_count <= 2'd0;
            end else if (!unlock && key_write) begin
                if (req.wdata == UNLOCK_KEY[unlock_count]) begin
                    if (unlock_count == KEY_LAST) begin
                        unlock_flag  <= 1'b1;
                        unlock_count <= 2'd0;
                    end else begin
                        unlock_count <= unlock_count + 2'd1;
                    end
                end else begin
                    unlock_count <= 2'd0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Registers, lock sequence and interrupts
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            unlock          <= 1'b0;
            lock_count      <= 1'b0;
            cmd_out.pending <= 1'b0;
            cmd_out.cmd     <= e_cmd'(8'h00);
            cmd_error       <= 1'b0;
            cmd_irq_request <= 1'b0;
            cmd_irq         <= 1'b0;
            ctrl_irq        <= 1'b0;
        end else begin
            // Completion from the executor is taken even while locked.
            if (cmd_out.pending && rsp.done) begin
                cmd_out.pending <= 1'b0;
                cmd_irq         <= cmd_irq_request;
                cmd_error       <= rsp.error;
            end

            if (rsp.ctrl_irq) begin
                ctrl_irq <= 1'b1;
            end

            if (unlock_flag) begin
                unlock <= 1'b1;
            end

            if (console_reset) begin
                unlock          <= 1'b0;
                lock_count      <= 1'b0;
                cmd_irq_request <= 1'b0;
                cmd_irq         <= 1'b0;
                ctrl_irq        <= 1'b0;
            end else if (unlock && write_hit) begin
                case (req.index)
                    REG_COMMAND: begin
                        if (!cmd_out.pending) begin
                            cmd_out.pending <= 1'b1;
                            cmd_out.cmd     <= e_cmd'(req.wdata[7:0]);
                            cmd_irq_request <= req.wdata[8];
                            cmd_error       <= 1'b0;
                        end
                    end
                    REG_DATA_0_H: begin
                        if (!cmd_out.pending) cmd_out.arg[0][31:16] <= req.wdata;
                    end
                    REG_DATA_0_L: begin
                        if (!cmd_out.pending) cmd_out.arg[0][15:0] <= req.wdata;
                    end
                    REG_DATA_1_H: begin
                        if (!cmd_out.pending) cmd_out.arg[1][31:16] <= req.wdata;
                    end
                    REG_DATA_1_L: begin
                        if (!cmd_out.pending) cmd_out.arg[1][15:0] <= req.wdata;
                    end
                    REG_KEY_H, REG_KEY_L: begin
                        // Two LOCK_WORD writes in a row close the window again.
                        if (req.wdata == LOCK_WORD) begin
                            lock_count <= !lock_count;
                            if (lock_count) begin
                                unlock <= 1'b0;
                            end
                        end else begin
                            lock_count <= 1'b0;
                        end
                    end
                    REG_IRQ_H: begin
                        if (req.wdata[15]) ctrl_irq <= 1'b0;
                        if (req.wdata[14]) cmd_irq <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- design/cfg_cmd_exec.sv
`timescale 1ns/1ps

module cfg_cmd_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  n64_cfg_pkg::cfg_cmd_t cmd_in,
    output n64_cfg_pkg::cfg_rsp_t rsp
);

    import n64_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } e_state;

    // Cycles spent in BUSY, so done lands three cycles after the start.
    localparam logic [1:0] BUSY_CYCLES = 2'd2;

    e_state           state;
    logic [1:0]       cycle_count;
    e_cmd             cmd_q;
    logic [1:0][31:0] arg_q;
    logic [1:0][31:0] result_next;
    logic             cmd_known;
    logic             cmd_raise;

    always_comb begin
        result_next = rsp.result;
        cmd_known   = 1'b1;
        cmd_raise   = 1'b0;
        case (cmd_q)
            CMD_ECHO: result_next = arg_q;
            CMD_SWAP: begin
                result_next[0] = arg_q[1];
                result_next[1] = arg_q[0];
            end
            CMD_ADD: begin
                result_next[0] = arg_q[0] + arg_q[1];
                result_next[1] = 32'd0;
            end
            CMD_RAISE_IRQ: begin
                result_next = arg_q;
                cmd_raise   = 1'b1;
            end
            default: cmd_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            cycle_count  <= 2'd0;
            rsp.done     <= 1'b0;
            rsp.error    <= 1'b0;
            rsp.ctrl_irq <= 1'b0;
            rsp.result   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_in.pending) begin
                        state       <= BUSY;
                        cycle_count <= 2'd0;
                        cmd_q       <= cmd_in.cmd;
                        arg_q       <= cmd_in.arg;
                    end
                end
                BUSY: begin
                    if (cycle_count == BUSY_CYCLES - 2'd1) begin
                        state        <= DONE;
                        rsp.done     <= 1'b1;
                        rsp.error    <= !cmd_known;
                        rsp.ctrl_irq <= cmd_raise;
                        rsp.result   <= result_next;
                    end else begin
                        cycle_count <= cycle_count + 2'd1;
                    end
                end
                default: begin
                    state        <= IDLE;
                    rsp.done     <= 1'b0;
                    rsp.error    <= 1'b0;
                    rsp.ctrl_irq <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- design/n64_cfg_top.sv
`timescale 1ns/1ps

module n64_cfg_top #(
    parameter logic [31:0] IDENTIFIER = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        n64_reset,
    input  logic        n64_nmi,
    input  logic [16:0] address,
    input  logic        write,
    input  logic [15:0] wdata,
    output logic [15:0] rdata,
    output logic        irq
);

    import n64_cfg_pkg::*;

    reg_req_t req;
    cfg_cmd_t cmd;
    cfg_rsp_t rsp;

    n64_bus_decode bus_decode_i (
        .clk     (clk),
        .reset   (reset),
        .address (address),
        .write   (write),
        .wdata   (wdata),
        .req     (req)
    );

    n64_cfg #(
        .IDENTIFIER (IDENTIFIER)
    ) cfg_i (
        .clk       (clk),
        .reset     (reset),
        .n64_reset (n64_reset),
        .n64_nmi   (n64_nmi),
        .req       (req),
        .cmd_out   (cmd),
        .rsp       (rsp),
        .rdata     (rdata),
        .irq       (irq)
    );

    cfg_cmd_exec cmd_exec_i (
        .clk    (clk),
        .reset  (reset),
        .cmd_in (cmd),
        .rsp    (rsp)
    );

endmodule

//--- sim/tb_n64_cfg.sv
`timescale 1ns/1ps

module tb_n64_cfg;

    import n64_cfg_pkg::*;

    localparam logic [31:0] IDENTIFIER = 32'h53433634;
    localparam int TIMEOUT_CYCLES = 50;

    logic        clk;
    logic        reset;
    logic        n64_reset;
    logic        n64_nmi;
    logic [16:0] address;
    logic        write;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        irq;

    logic [15:0] lfsr_state;
    logic [31:0] arg0;
    logic [31:0] arg1;

    n64_cfg_top #(
        .IDENTIFIER (IDENTIFIER)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .n64_reset (n64_reset),
        .n64_nmi   (n64_nmi),
        .address   (address),
        .write     (write),
        .wdata     (wdata),
        .rdata     (rdata),
        .irq       (irq)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // The window base has bit 16 set and the register index sits in bits 4 to 1.
    function automatic logic [16:0] reg_address(e_reg index);
        return {1'b1, 11'd0, index, 1'b0};
    endfunction

    // Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit.
    function automatic logic [31:0] random_word();
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value = {value[30:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0],
                lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        end
        return value;
    endfunction

    task automatic stop_on_error(string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(string test_name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h",
                test_name, expected, actual));
        end
    endtask

    task automatic bus_write(e_reg index, logic [15:0] value);
        address = reg_address(index);
        write   = 1'b1;
        wdata   = value;
        @(negedge clk);
        write   = 1'b0;
    endtask

    // The read data shows the request registered one cycle earlier.
    task automatic bus_read(e_reg index, output logic [15:0] value);
        address = reg_address(index);
        write   = 1'b0;
        @(negedge clk);
        value = rdata;
    endtask

    task automatic check_reg(string test_name, e_reg index, logic [15:0] expected);
        logic [15:0] value;
        bus_read(index, value);
        check_value(test_name, 32'(expected), 32'(value));
    endtask

    task automatic wait_not_pending();
        logic [15:0] status;
        int          cycles;
        cycles = 0;
        status = 16'hFFFF;
        while (status[15] !== 1'b0) begin
            if (cycles == TIMEOUT_CYCLES) begin
                stop_on_error("Timeout: the command never left the pending state");
            end
            bus_read(REG_STATUS, status);
            cycles++;
        end
    endtask

    task automatic wait_irq(string test_name, logic expected);
        int cycles;
        cycles = 0;
        while (irq !== expected) begin
            if (cycles == TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("Timeout: irq never went to %0b in %s",
                    expected, test_name));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic unlock_block();
        for (int i = 0; i < UNLOCK_KEY_LEN; i++) begin
            bus_write(REG_KEY_H, UNLOCK_KEY[i]);
        end
        // Unlock lands one cycle after the last key word is taken.
        @(negedge clk);
    endtask

    task automatic write_args(logic [31:0] a0, logic [31:0] a1);
        bus_write(REG_DATA_0_H, a0[31:16]);
        bus_write(REG_DATA_0_L, a0[15:0]);
        bus_write(REG_DATA_1_H, a1[31:16]);
        bus_write(REG_DATA_1_L, a1[15:0]);
    endtask

    task automatic issue_command(logic [7:0] cmd, logic irq_request);
        bus_write(REG_COMMAND, {7'd0, irq_request, cmd});
        wait_not_pending();
    endtask

    task automatic check_results(string test_name, logic [31:0] r0, logic [31:0] r1);
        check_reg(test_name, REG_DATA_0_H, r0[31:16]);
        check_reg(test_name, REG_DATA_0_L, r0[15:0]);
        check_reg(test_name, REG_DATA_1_H, r1[31:16]);
        check_reg(test_name, REG_DATA_1_L, r1[15:0]);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    task automatic test_reset_values();
        check_reg("reset identifier", REG_IDENTIFIER_H, 16'h5343);
        check_reg("reset identifier", REG_IDENTIFIER_L, 16'h3634);
        check_reg("reset status", REG_STATUS, 16'h0000);
        check_reg("reset command", REG_COMMAND, 16'h0000);
        check_value("reset irq", 32'd0, 32'(irq));
    endtask

    task automatic test_locked_access();
        bus_write(REG_DATA_0_H, 16'h1234);
        bus_write(REG_COMMAND, 16'(CMD_ECHO));
        check_reg("locked status", REG_STATUS, 16'h0000);
        check_reg("locked command", REG_COMMAND, 16'h0000);
        check_reg("locked data", REG_DATA_0_H, 16'h0000);

        bus_write(REG_KEY_H, UNLOCK_KEY[0]);
        bus_write(REG_KEY_L, UNLOCK_KEY[1]);
        bus_write(REG_KEY_H, 16'h1111);
        bus_write(REG_KEY_L, UNLOCK_KEY[3]);
        @(negedge clk);
        bus_write(REG_COMMAND, 16'(CMD_ECHO));
        check_reg("wrong key", REG_STATUS, 16'h0000);

        unlock_block();
        arg0 = random_word();
        arg1 = random_word();
        write_args(arg0, arg1);
        issue_command(CMD_ECHO, 1'b0);
        check_results("unlocked echo", arg0, arg1);
    endtask

    task automatic test_commands();
        arg0 = random_word();
        arg1 = random_word();
        write_args(arg0, arg1);
        issue_command(CMD_ECHO, 1'b0);
        check_results("echo", arg0, arg1);
        check_reg("echo status", REG_STATUS, 16'h0000);
        issue_command(CMD_SWAP, 1'b0);
        check_results("swap", arg1, arg0);
        check_reg("swap status", REG_STATUS, 16'h0000);
        issue_command(CMD_ADD, 1'b0);
        check_results("add", arg0 + arg1, 32'd0);
        check_reg("add status", REG_STATUS, 16'h0000);
    endtask

    // New arguments go in first, so any result computed from them shows up.
    task automatic test_unknown_opcode();
        logic [31:0] previous_sum;
        previous_sum = arg0 + arg1;
        arg0 = random_word();
        arg1 = random_word();
        write_args(arg0, arg1);
        issue_command(8'h7E, 1'b0);
        check_reg("unknown opcode status", REG_STATUS, 16'h4000);
        check_results("unknown opcode", previous_sum, 32'd0);
    endtask

    task automatic test_interrupts();
        issue_command(CMD_ECHO, 1'b1);
        check_reg("cmd irq command", REG_COMMAND, 16'h0101);
        check_reg("cmd irq status", REG_STATUS, 16'h1000);
        wait_irq("cmd irq set", 1'b1);
        bus_write(REG_IRQ_H, 16'h4000);
        check_reg("cmd irq clear", REG_STATUS, 16'h0000);
        wait_irq("cmd irq clear", 1'b0);

        arg0 = random_word();
        arg1 = random_word();
        write_args(arg0, arg1);
        issue_command(CMD_RAISE_IRQ, 1'b0);
        check_reg("ctrl irq status", REG_STATUS, 16'h2000);
        check_results("raise irq", arg0, arg1);
        wait_irq("ctrl irq set", 1'b1);
        bus_write(REG_IRQ_H, 16'h8000);
        check_reg("ctrl irq clear", REG_STATUS, 16'h0000);
        wait_irq("ctrl irq clear", 1'b0);
    endtask

    task automatic test_console_reset();
        n64_nmi = 1'b1;
        @(negedge clk);
        n64_nmi = 1'b0;
        bus_write(REG_DATA_0_H, ~arg0[31:16]);
        bus_write(REG_COMMAND, 16'(CMD_ECHO));
        check_reg("nmi relock", REG_STATUS, 16'h0000);

        unlock_block();
        issue_command(CMD_ECHO, 1'b0);
        check_results("nmi data ignored", arg0, arg1);

        bus_write(REG_KEY_H, LOCK_WORD);
        bus_write(REG_KEY_L, LOCK_WORD);
        bus_write(REG_COMMAND, 16'(CMD_SWAP));
        check_reg("lock word", REG_STATUS, 16'h0000);
        check_results("lock word", arg0, arg1);

        unlock_block();
        n64_reset = 1'b1;
        @(negedge clk);
        n64_reset = 1'b0;
        bus_write(REG_COMMAND, 16'(CMD_SWAP));
        check_reg("console reset relock", REG_STATUS, 16'h0000);
        check_results("console reset relock", arg0, arg1);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        n64_reset  = 1'b0;
        n64_nmi    = 1'b0;
        address    = '0;
        write      = 1'b0;
        wdata      = '0;
        lfsr_state = 16'd17;
        arg0       = '0;
        arg1       = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_values();
        test_locked_access();
        test_commands();
        test_unknown_opcode();
        test_interrupts();
        test_console_reset();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- sources.f
design/n64_cfg_pkg.sv
design/n64_bus_decode.sv
design/n64_cfg.sv
design/cfg_cmd_exec.sv
design/n64_cfg_top.sv
sim/tb_n64_cfg.sv

//--- Bender.yml
package:
  name: n64_cfg

sources:
  - design/n64_cfg_pkg.sv
  - design/n64_bus_decode.sv
  - design/n64_cfg.sv
  - design/cfg_cmd_exec.sv
  - design/n64_cfg_top.sv
  - target: simulation
    files:
      - sim/tb_n64_cfg.sv
